/* files.f */
dm_pkg.sv
dmi_if.sv
sync_2ff.sv
async_hs_fifo.sv
dmi_cdc.sv
dmi_regfile.sv
dmi_subsys_top.sv
tb_dmi_subsys.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_dmi_subsys -f files.f
	@out="$$(./obj_dir/Vtb_dmi_subsys 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

/* tb_dmi_subsys.sv */
`timescale 1ns/10ps

module tb_dmi_subsys;
  import dm_pkg::*;

  // Cycle limit for every wait loop
  localparam int unsigned Timeout = 1000;

  logic        tck_i;
  logic        trst_ni;
  logic        clk_i;
  logic        rst_ni;
  logic        testmode_i;
  logic        test_rst_ni;
  logic [6:0]  addr;
  logic [1:0]  op;
  logic [31:0] wdata;
  logic        req_valid;
  logic        cdc_clear;
  logic        req_ready;
  logic [31:0] rdata;
  logic [1:0]  status;
  logic        resp_valid;
  logic        resp_ready = 1'b0;

  // Reference model, register contents and expected responses in order
  logic [31:0] model_regs [NumDbgRegs];
  dmi_resp_t   exp_q [$];
  logic        bp_en;
  int unsigned stall_cnt = 0;

  dmi_subsys_top DUT (
    .tck_i                 (tck_i),
    .trst_ni               (trst_ni),
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .testmode_i            (testmode_i),
    .test_rst_ni           (test_rst_ni),
    .jtag_dmi_addr_i       (addr),
    .jtag_dmi_op_i         (op),
    .jtag_dmi_wdata_i      (wdata),
    .jtag_dmi_req_valid_i  (req_valid),
    .jtag_dmi_cdc_clear_i  (cdc_clear),
    .jtag_dmi_req_ready_o  (req_ready),
    .jtag_dmi_rdata_o      (rdata),
    .jtag_dmi_status_o     (status),
    .jtag_dmi_resp_valid_o (resp_valid),
    .jtag_dmi_resp_ready_i (resp_ready)
  );

  // JTAG clock, 10 ns
  initial begin
    tck_i = 1'b0;
    forever #5 tck_i = ~tck_i;
  end

  // Core clock, 7 ns, unrelated to tck
  initial begin
    clk_i = 1'b0;
    forever #3.5 clk_i = ~clk_i;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("mismatch at %0t: %s expected 0x%08h got 0x%08h", $time, name, want, got);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: no %s within %0d tck cycles", what, Timeout);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  // Response side
  // Random stalls on ready, each transfer popped and compared in order
  always @(negedge tck_i) begin
    dmi_resp_t want;
    if (stall_cnt != 0) begin
      resp_ready = 1'b0;
      stall_cnt  = stall_cnt - 1;
    end else if (bp_en && $urandom_range(3, 0) == 0) begin
      resp_ready = 1'b0;
      stall_cnt  = $urandom_range(15, 0);
    end else begin
      resp_ready = 1'b1;
    end
    // Transfer happens on the coming rising edge
    if (resp_valid && resp_ready) begin
      if (exp_q.size() == 0) begin
        $display("error at %0t: response arrived with no request outstanding", $time);
        $display(">>> FAIL");
        $fatal(1);
      end else begin
        want = exp_q.pop_front();
        check_val("jtag_dmi_rdata_o", rdata, want.data);
        check_val("jtag_dmi_status_o", 32'(status), 32'(want.resp));
      end
    end
  end

  // One request, model updated at issue
  task automatic send_req(input logic [6:0] a, input logic [1:0] o, input logic [31:0] d);
    dmi_resp_t   want;
    int unsigned cnt;
    addr      = a;
    op        = o;
    wdata     = d;
    req_valid = 1'b1;
    cnt       = 0;
    while (!req_ready) begin
      @(negedge tck_i);
      cnt++;
      if (cnt >= Timeout) report_timeout("request ready");
    end
    want.data = '0;
    want.resp = dmi_success;
    if (32'(a) >= NumDbgRegs) begin
      want.resp = dmi_failed;
    end else if (o == dmi_read) begin
      want.data = model_regs[a[DbgRegIdxWidth-1:0]];
    end else if (o == dmi_write) begin
      model_regs[a[DbgRegIdxWidth-1:0]] = d;
      want.data = d;
    end
    exp_q.push_back(want);
    @(negedge tck_i);
    req_valid = 1'b0;
  endtask

  // All responses back and request crossing free again
  task automatic wait_idle();
    int unsigned cnt;
    cnt = 0;
    while (exp_q.size() != 0 || !req_ready) begin
      @(negedge tck_i);
      cnt++;
      if (cnt >= Timeout) report_timeout("drain of outstanding responses");
    end
  endtask

  task automatic read_all();
    for (int i = 0; i < NumDbgRegs; i++) send_req(7'(i), dmi_read, $urandom());
  endtask

  // Nonzero data so a later clear is visible
  task automatic write_all();
    for (int i = 0; i < NumDbgRegs; i++) send_req(7'(i), dmi_write, $urandom() | 32'h1);
  endtask

  task automatic random_ops(input int n, input int lo, input int hi);
    for (int i = 0; i < n; i++) begin
      send_req(7'($urandom_range(hi, lo)), 2'($urandom_range(2, 0)), $urandom());
    end
  endtask

  initial begin
    void'($urandom(96));
    trst_ni     = 1'b0;
    rst_ni      = 1'b0;
    testmode_i  = 1'b0;
    test_rst_ni = 1'b1;
    addr        = '0;
    op          = '0;
    wdata       = '0;
    req_valid   = 1'b0;
    cdc_clear   = 1'b0;
    bp_en       = 1'b0;
    model_regs  = '{default: '0};
    repeat (5) @(negedge tck_i);
    trst_ni = 1'b1;
    rst_ni  = 1'b1;
    // Idle handshake state out of reset
    check_val("jtag_dmi_req_ready_o", 32'(req_ready), 32'd1);
    check_val("jtag_dmi_resp_valid_o", 32'(resp_valid), 32'd0);
    // Bank comes up all zero
    read_all();
    // In-range traffic, second half under back-pressure
    random_ops(150, 0, 15);
    bp_en = 1'b1;
    random_ops(150, 0, 15);
    // Out-of-range addresses fail and touch nothing
    random_ops(40, 16, 127);
    read_all();
    wait_idle();
    // CDC clear resets the core side
    write_all();
    wait_idle();
    repeat (10) @(negedge tck_i);
    cdc_clear = 1'b1;
    @(negedge tck_i);
    cdc_clear = 1'b0;
    repeat (10) @(negedge tck_i);
    model_regs = '{default: '0};
    read_all();
    random_ops(50, 0, 15);
    write_all();
    wait_idle();
    // Test-mode reset from the tester pin
    repeat (10) @(negedge tck_i);
    testmode_i = 1'b1;
    repeat (2) @(negedge tck_i);
    test_rst_ni = 1'b0;
    repeat (5) @(negedge tck_i);
    test_rst_ni = 1'b1;
    repeat (2) @(negedge tck_i);
    testmode_i = 1'b0;
    repeat (5) @(negedge tck_i);
    model_regs = '{default: '0};
    read_all();
    wait_idle();
    // Quiet window, nothing extra may show up
    repeat (20) @(negedge tck_i);
    check_val("jtag_dmi_resp_valid_o", 32'(resp_valid), 32'd0);
    $display(">>> PASS");
    $finish;
  end

endmodule : tb_dmi_subsys

/* dmi_subsys_top.sv */
`timescale 1ns/10ps

// DMI subsystem, JTAG-side ports in, debug register bank on the core clock
module dmi_subsys_top (
  // Clocks, resets, test controls
  input  logic                            tck_i,
  input  logic                            trst_ni,
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            testmode_i,
  input  logic                            test_rst_ni,
  // Request
  input  logic [dm_pkg::DmiAddrWidth-1:0] jtag_dmi_addr_i,
  input  logic [1:0]                      jtag_dmi_op_i,
  input  logic [dm_pkg::DmiDataWidth-1:0] jtag_dmi_wdata_i,
  input  logic                            jtag_dmi_req_valid_i,
  input  logic                            jtag_dmi_cdc_clear_i,
  output logic                            jtag_dmi_req_ready_o,
  // Response
  output logic [dm_pkg::DmiDataWidth-1:0] jtag_dmi_rdata_o,
  output logic [1:0]                      jtag_dmi_status_o,
  output logic                            jtag_dmi_resp_valid_o,
  input  logic                            jtag_dmi_resp_ready_i
);
  import dm_pkg::*;

  dmi_req_t  jtag_req;
  dmi_resp_t jtag_resp;
  logic      core_rst_n;

  // Core-side DMI link
  dmi_if core_dmi ();

  // Pack request fields
  assign jtag_req.addr = jtag_dmi_addr_i;
  assign jtag_req.op   = dmi_op_e'(jtag_dmi_op_i);
  assign jtag_req.data = jtag_dmi_wdata_i;

  // Unpack response fields
  assign jtag_dmi_rdata_o  = jtag_resp.data;
  assign jtag_dmi_status_o = jtag_resp.resp;

  dmi_cdc u_dmi_cdc (
    .testmode_i        (testmode_i),
    .test_rst_ni       (test_rst_ni),
    .tck_i             (tck_i),
    .trst_ni           (trst_ni),
    .jtag_req_i        (jtag_req),
    .jtag_req_valid_i  (jtag_dmi_req_valid_i),
    .jtag_req_ready_o  (jtag_dmi_req_ready_o),
    .jtag_cdc_clear_i  (jtag_dmi_cdc_clear_i),
    .jtag_resp_o       (jtag_resp),
    .jtag_resp_valid_o (jtag_dmi_resp_valid_o),
    .jtag_resp_ready_i (jtag_dmi_resp_ready_i),
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .core_rst_no       (core_rst_n),
    .core_dmi          (core_dmi.master)
  );

  // Bank reset follows the sequenced core reset
  dmi_regfile u_dmi_regfile (
    .clk_i  (clk_i),
    .rst_ni (core_rst_n),
    .dmi    (core_dmi.slave)
  );

endmodule : dmi_subsys_top

/* dmi_regfile.sv */
`timescale 1ns/10ps

// Core-side debug register bank behind a DMI slave port
module dmi_regfile (
  input  logic clk_i,
  input  logic rst_ni,
  dmi_if.slave dmi
);
  import dm_pkg::*;

  logic [DmiDataWidth-1:0]   regs_q [NumDbgRegs];
  logic [DbgRegIdxWidth-1:0] reg_idx;
  logic                      in_range;
  logic                      req_xfer;
  logic                      resp_valid_q;
  dmi_resp_t                 resp_d;
  dmi_resp_t                 resp_q;

  // One response in flight at most
  assign dmi.req_ready = !resp_valid_q;
  assign req_xfer      = dmi.req_valid && dmi.req_ready;

  // Address decode
  assign in_range = dmi.req.addr < DmiAddrWidth'(NumDbgRegs);
  assign reg_idx  = dmi.req.addr[DbgRegIdxWidth-1:0];

  // Response for the current request
  always_comb begin
    resp_d.data = '0;
    resp_d.resp = dmi_success;
    if (!in_range) begin
      resp_d.resp = dmi_failed;
    end else begin
      case (dmi.req.op)
        dmi_read:  resp_d.data = regs_q[reg_idx];
        // Echo written data
        dmi_write: resp_d.data = dmi.req.data;
        default:   resp_d.data = '0;
      endcase
    end
  end

  // Register bank, cleared by core reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '{default: '0};
    end else if (req_xfer && in_range && dmi.req.op == dmi_write) begin
      regs_q[reg_idx] <= dmi.req.data;
    end
  end

  // Response valid, set on accept and cleared on hand-off
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else if (req_xfer) begin
      resp_valid_q <= 1'b1;
    end else if (dmi.resp_ready) begin
      resp_valid_q <= 1'b0;
    end
  end

  // Response payload
  always_ff @(posedge clk_i) begin
    if (req_xfer) begin
      resp_q <= resp_d;
    end
  end

  assign dmi.resp_valid = resp_valid_q;
  assign dmi.resp       = resp_q;

  // Master holds a blocked request until the bank takes it
  a_req_held : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (dmi.req_valid && !dmi.req_ready) |=> (dmi.req_valid && $stable(dmi.req))
  ) else $error("dmi_regfile: request dropped or changed before it was taken");

endmodule : dmi_regfile

/* dmi_cdc.sv */
`timescale 1ns/10ps

// DMI crossing between tck and core clock, with reset sequencing
module dmi_cdc (
  // Test controls
  input  logic              testmode_i,
  input  logic              test_rst_ni,
  // JTAG side
  input  logic              tck_i,
  input  logic              trst_ni,
  input  dm_pkg::dmi_req_t  jtag_req_i,
  input  logic              jtag_req_valid_i,
  output logic              jtag_req_ready_o,
  input  logic              jtag_cdc_clear_i,
  output dm_pkg::dmi_resp_t jtag_resp_o,
  output logic              jtag_resp_valid_o,
  input  logic              jtag_resp_ready_i,
  // Core side
  input  logic              clk_i,
  input  logic              rst_ni,
  output logic              core_rst_no,
  dmi_if.master             core_dmi
);
  import dm_pkg::*;

  logic jtag_rst_nq;
  logic core_rst_sync;
  logic combined_rst_n;

  // JTAG-side reset request, low on trst or clear
  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      jtag_rst_nq <= 1'b0;
    end else if (jtag_cdc_clear_i) begin
      jtag_rst_nq <= 1'b0;
    end else begin
      jtag_rst_nq <= 1'b1;
    end
  end

  // Bring it into the core clock
  sync_2ff u_rst_sync (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (jtag_rst_nq),
    .q_o    (core_rst_sync)
  );

  // Test mode hands reset straight to the tester
  assign combined_rst_n = testmode_i ? test_rst_ni : core_rst_sync;
  assign core_rst_no    = combined_rst_n;

  // Requests, tck to clk
  async_hs_fifo #(
    .data_t (dmi_req_t)
  ) u_cdc_req (
    .wclk_i   (tck_i),
    .wrst_ni  (trst_ni),
    .wvalid_i (jtag_req_valid_i),
    .wdata_i  (jtag_req_i),
    .wready_o (jtag_req_ready_o),
    .rclk_i   (clk_i),
    .rrst_ni  (combined_rst_n),
    .rvalid_o (core_dmi.req_valid),
    .rready_i (core_dmi.req_ready),
    .rdata_o  (core_dmi.req)
  );

  // Responses, clk to tck
  async_hs_fifo #(
    .data_t (dmi_resp_t)
  ) u_cdc_resp (
    .wclk_i   (clk_i),
    .wrst_ni  (combined_rst_n),
    .wvalid_i (core_dmi.resp_valid),
    .wdata_i  (core_dmi.resp),
    .wready_o (core_dmi.resp_ready),
    .rclk_i   (tck_i),
    .rrst_ni  (trst_ni),
    .rvalid_o (jtag_resp_valid_o),
    .rready_i (jtag_resp_ready_i),
    .rdata_o  (jtag_resp_o)
  );

  // Outside test mode a JTAG-side reset reaches the core within two clocks
  a_clear_reaches_core : assert property (
    @(posedge clk_i) disable iff (testmode_i)
    !$past(jtag_rst_nq, 2) |-> !core_rst_no
  ) else $error("dmi_cdc: JTAG-side reset did not reach the core reset");

endmodule : dmi_cdc

/* async_hs_fifo.sv */
`timescale 1ns/10ps

// Single-entry clock crossing, four-phase return-to-zero handshake
module async_hs_fifo #(
  parameter type data_t = dm_pkg::dmi_req_t
) (
  // Write domain
  input  logic  wclk_i,
  input  logic  wrst_ni,
  input  logic  wvalid_i,
  input  data_t wdata_i,
  output logic  wready_o,
  // Read domain
  input  logic  rclk_i,
  input  logic  rrst_ni,
  output logic  rvalid_o,
  input  logic  rready_i,
  output data_t rdata_o
);

  // Writer state
  logic  wreq_q;
  data_t wdata_q;
  logic  wack_sync;
  logic  wxfer;

  // Reader state
  logic  rreq_sync;
  logic  rack_q;
  logic  rxfer;

  // Free only when both req and ack are back at zero
  assign wready_o = !wreq_q && !wack_sync;
  assign wxfer    = wvalid_i && wready_o;

  // Req level, up on capture, down once ack is seen
  always_ff @(posedge wclk_i or negedge wrst_ni) begin
    if (!wrst_ni) begin
      wreq_q <= 1'b0;
    end else if (wxfer) begin
      wreq_q <= 1'b1;
    end else if (wreq_q && wack_sync) begin
      wreq_q <= 1'b0;
    end
  end

  // Holding register
  // Stays put for the whole handshake so the reader may sample it freely
  always_ff @(posedge wclk_i) begin
    if (wxfer) begin
      wdata_q <= wdata_i;
    end
  end

  // Req into read domain
  sync_2ff u_req_sync (
    .clk_i  (rclk_i),
    .rst_ni (rrst_ni),
    .d_i    (wreq_q),
    .q_o    (rreq_sync)
  );

  // Word offered while req high and not yet taken
  assign rvalid_o = rreq_sync && !rack_q;
  assign rdata_o  = wdata_q;
  assign rxfer    = rvalid_o && rready_i;

  // Ack level, up on accept, down when req has dropped
  always_ff @(posedge rclk_i or negedge rrst_ni) begin
    if (!rrst_ni) begin
      rack_q <= 1'b0;
    end else if (rxfer) begin
      rack_q <= 1'b1;
    end else if (rack_q && !rreq_sync) begin
      rack_q <= 1'b0;
    end
  end

  // Ack back into write domain
  sync_2ff u_ack_sync (
    .clk_i  (wclk_i),
    .rst_ni (wrst_ni),
    .d_i    (rack_q),
    .q_o    (wack_sync)
  );

  // Writer must hold its word while blocked
  a_wdata_stable : assert property (
    @(posedge wclk_i) disable iff (!wrst_ni)
    (wvalid_i && !wready_o) |=> (!wvalid_i || $stable(wdata_i))
  ) else $error("async_hs_fifo: wdata_i changed while blocked");

  // A new word only after ack has fully returned to zero
  a_rvalid_after_rz : assert property (
    @(posedge rclk_i) disable iff (!rrst_ni)
    $rose(rvalid_o) |-> !$past(rack_q)
  ) else $error("async_hs_fifo: rvalid_o rose before ack returned to zero");

endmodule : async_hs_fifo

/* sync_2ff.sv */
`timescale 1ns/10ps

// Two-flop synchronizer for one level signal
module sync_2ff (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic d_i,
  output logic q_o
);

  // First stage, may go metastable
  logic meta_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_q <= 1'b0;
      q_o    <= 1'b0;
    end else begin
      // Second stage resolves the first
      meta_q <= d_i;
      q_o    <= meta_q;
    end
  end

endmodule : sync_2ff

/* dmi_if.sv */
`timescale 1ns/10ps

// One DMI port, request channel plus response channel
interface dmi_if;
  import dm_pkg::*;

  // Request channel, master to slave
  logic      req_valid;
  logic      req_ready;
  dmi_req_t  req;

  // Response channel, slave to master
  logic      resp_valid;
  logic      resp_ready;
  dmi_resp_t resp;

  // Requesting side
  modport master (
    output req,
    output req_valid,
    input  req_ready,
    input  resp,
    input  resp_valid,
    output resp_ready
  );

  // Serving side
  modport slave (
    input  req,
    input  req_valid,
    output req_ready,
    output resp,
    output resp_valid,
    input  resp_ready
  );

endinterface : dmi_if

/* dm_pkg.sv */
package dm_pkg;

  // DMI field widths
  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned DmiDataWidth = 32;

  // Debug register bank size
  localparam int unsigned NumDbgRegs = 16;
  // Index bits needed to select one bank register
  localparam int unsigned DbgRegIdxWidth = $clog2(NumDbgRegs);

  // Request opcodes, DTM encoding
  typedef enum logic [1:0] {
    dmi_nop   = 2'h0,
    dmi_read  = 2'h1,
    dmi_write = 2'h2
  } dmi_op_e;

  // Response status, DTM encoding
  // Busy kept for encoding completeness only
  typedef enum logic [1:0] {
    dmi_success = 2'h0,
    dmi_failed  = 2'h2,
    dmi_busy    = 2'h3
  } dmi_status_e;

  // Request word, 41 bits
  typedef struct packed {
    logic [DmiAddrWidth-1:0] addr;
    dmi_op_e                 op;
    logic [DmiDataWidth-1:0] data;
  } dmi_req_t;

  // Response word, 34 bits
  typedef struct packed {
    logic [DmiDataWidth-1:0] data;
    dmi_status_e             resp;
  } dmi_resp_t;

endpackage : dm_pkg
